//--- src/trace_pkg.sv
// ****************************************
// trace entry types shared by encoder, FIFO and regs
// payload is 64 bits, decoded by entry kind
// ****************************************
`default_nettype none

package trace_pkg;

  // reduced RVFI-style retirement record
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] insn;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    logic        trap;
    logic [1:0]  mode;
  } retire_t;

  typedef enum logic [1:0] {
    KIND_INSN = 2'd0,
    KIND_TRAP = 2'd1,
    KIND_WB   = 2'd2
  } entry_kind_e;

  // insn and trap entries use insn_view, writeback entries use wb_view
  typedef union packed {
    struct packed {
      logic [31:0] pc;
      logic [31:0] insn;
    } insn_view;
    struct packed {
      logic [26:0] pad;
      logic [4:0]  rd_addr;
      logic [31:0] wdata;
    } wb_view;
  } entry_payload_u;

  typedef struct packed {
    entry_kind_e    kind;
    entry_payload_u payload;
  } trace_entry_t;

endpackage

`default_nettype wire

//--- src/trace_axil_pkg.sv
// ****************************************
// register map of the trace AXI4-Lite slave
// offsets are byte addresses, word aligned
// ****************************************
`default_nettype none

package trace_axil_pkg;

  localparam logic [7:0] REG_CTRL      = 8'h00;
  localparam logic [7:0] REG_STATUS    = 8'h04;
  localparam logic [7:0] REG_DROPS     = 8'h08;
  localparam logic [7:0] REG_HEAD_KIND = 8'h0C;
  localparam logic [7:0] REG_HEAD_LO   = 8'h10;
  localparam logic [7:0] REG_HEAD_HI   = 8'h14;
  localparam logic [7:0] REG_FLUSH     = 8'h18;

  // CTRL field layout, mode_mask is indexed by privilege mode
  localparam int unsigned CTRL_W          = 6;
  localparam int unsigned CTRL_ENABLE_BIT = 0;
  localparam int unsigned CTRL_MODE_LSB   = 1;
  localparam int unsigned CTRL_MODE_MSB   = 4;
  localparam int unsigned CTRL_WB_EN_BIT  = 5;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- src/trace_ifs.sv
// ****************************************
// config and FIFO read interfaces
// pop and flush are single-cycle pulses
// ****************************************
`timescale 1ns/1ns
`default_nettype none

// configuration toward the encoder, drop report back
interface trace_cfg_if;

  logic       enable;
  logic [3:0] mode_mask;
  logic       wb_en;
  logic       drop_pulse;

  modport regs (
    output enable,
    output mode_mask,
    output wb_en,
    input  drop_pulse
  );

  modport encoder (
    input  enable,
    input  mode_mask,
    input  wb_en,
    output drop_pulse
  );

endinterface

// FIFO read side as seen by the register block
interface trace_rd_if import trace_pkg::*; #(
  parameter int unsigned FifoDepth = 16
);

  localparam int unsigned CountW = $clog2(FifoDepth) + 1;

  logic              pop;
  logic              flush;
  trace_entry_t      head;
  logic              empty;
  logic [CountW-1:0] count;

  modport regs (
    output pop,
    output flush,
    input  head,
    input  empty,
    input  count
  );

  modport fifo (
    input  pop,
    input  flush,
    output head,
    output empty,
    output count
  );

endinterface

`default_nettype wire

//--- src/trace_encoder.sv
// ****************************************
// one register stage between retirement and FIFO
// no stall toward the core, short space drops
// the whole retirement
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module trace_encoder import trace_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  logic                  retire_valid_i,
  input  retire_t               retire_i,

  trace_cfg_if.encoder          cfg,

  input  logic [1:0]            free_i,
  output logic                  wr_en_o,
  output logic                  wr_two_o,
  output trace_entry_t          wr_entry0_o,
  output trace_entry_t          wr_entry1_o
);

  logic    accept;
  logic    want_wb;
  logic    valid_q;
  logic    two_q;
  retire_t ret_q;
  logic [1:0] need;
  logic    fits;

  // filter by enable and privilege mode
  assign accept  = retire_valid_i & cfg.enable & cfg.mode_mask[retire_i.mode];

  // writeback entry only for a real register write without trap
  assign want_wb = cfg.wb_en & (retire_i.rd_addr != 5'd0) & ~retire_i.trap;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      two_q   <= 1'b0;
    end else begin
      valid_q <= accept;
      two_q   <= accept & want_wb;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      ret_q <= retire_i;
    end
  end

  assign need = two_q ? 2'd2 : 2'd1;
  assign fits = (free_i >= need);

  assign wr_en_o        = valid_q & fits;
  assign wr_two_o       = valid_q & two_q & fits;
  assign cfg.drop_pulse = valid_q & ~fits;

  always_comb begin
    wr_entry0_o = '0;
    wr_entry0_o.kind = ret_q.trap ? KIND_TRAP : KIND_INSN;
    wr_entry0_o.payload.insn_view.pc   = ret_q.pc;
    wr_entry0_o.payload.insn_view.insn = ret_q.insn;

    // pad bits stay zero from the default above
    wr_entry1_o = '0;
    wr_entry1_o.kind = KIND_WB;
    wr_entry1_o.payload.wb_view.rd_addr = ret_q.rd_addr;
    wr_entry1_o.payload.wb_view.wdata   = ret_q.rd_wdata;
  end

endmodule

`default_nettype wire

//--- src/trace_fifo.sv
// ****************************************
// FifoDepth must be a power of two
// writer must respect free_o, no overflow check
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module trace_fifo import trace_pkg::*; #(
  parameter int unsigned FifoDepth = 16
) (
  input  logic         clk_i,
  input  logic         arst_n_i,

  input  logic         wr_en_i,
  input  logic         wr_two_i,
  input  trace_entry_t wr_entry0_i,
  input  trace_entry_t wr_entry1_i,
  output logic [1:0]   free_o,

  trace_rd_if.fifo     rd
);

  localparam int unsigned PtrW   = $clog2(FifoDepth);
  localparam int unsigned CountW = PtrW + 1;
  localparam logic [CountW-1:0] Depth = CountW'(FifoDepth);

  trace_entry_t      mem [FifoDepth];
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   wr_ptr_nxt;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [CountW-1:0] count_q;
  logic [CountW-1:0] wr_num;
  logic [CountW-1:0] space;
  logic              do_pop;

  assign wr_num     = wr_en_i ? (wr_two_i ? CountW'(2) : CountW'(1)) : '0;
  assign wr_ptr_nxt = wr_ptr_q + PtrW'(1);
  assign do_pop     = rd.pop & (count_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (rd.flush) begin
      // flush wins over a write in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PtrW'(wr_num);
      rd_ptr_q <= rd_ptr_q + PtrW'(do_pop);
      count_q  <= count_q + wr_num - CountW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i && !rd.flush) begin
      mem[wr_ptr_q] <= wr_entry0_i;
      if (wr_two_i) begin
        mem[wr_ptr_nxt] <= wr_entry1_i;
      end
    end
  end

  assign space  = Depth - count_q;
  assign free_o = (space >= CountW'(2)) ? 2'd2 : space[1:0];

  assign rd.head  = mem[rd_ptr_q];
  assign rd.empty = (count_q == '0);
  assign rd.count = count_q;

endmodule

`default_nettype wire

//--- src/trace_regs.sv
// ****************************************
// AXI4-Lite slave, 8-bit byte addresses, no wstrb
// one outstanding write and one outstanding read
// reading HEAD_HI pops the FIFO
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module trace_regs
  import trace_pkg::*;
  import trace_axil_pkg::*;
#(
  parameter int unsigned FifoDepth = 16
) (
  input  logic        clk_i,
  input  logic        arst_n_i,

  input  logic [7:0]  awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [7:0]  araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,

  trace_cfg_if.regs   cfg,
  trace_rd_if.regs    rd
);

  localparam int unsigned CountW = $clog2(FifoDepth) + 1;

  logic [CTRL_W-1:0] ctrl_q;
  logic [31:0]       drops_q;
  logic              bvalid_q;
  logic              rvalid_q;
  logic [1:0]        bresp_q;
  logic [1:0]        rresp_q;
  logic [31:0]       rdata_q;
  logic              wr_accept;
  logic              rd_accept;
  logic              wr_ok;
  logic              rd_ok;
  logic [31:0]       rd_word;
  logic [CountW-1:0] count;
  trace_entry_t      head;

  // write needs both channels and a free response slot
  assign wr_accept = awvalid_i & wvalid_i & ~bvalid_q;
  assign rd_accept = arvalid_i & ~rvalid_q;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign arready_o = rd_accept;

  assign wr_ok = (awaddr_i == REG_CTRL) | (awaddr_i == REG_DROPS) | (awaddr_i == REG_FLUSH);

  assign rd.flush = wr_accept & (awaddr_i == REG_FLUSH) & wdata_i[0];
  assign rd.pop   = rd_accept & (araddr_i == REG_HEAD_HI) & ~rd.empty;

  assign cfg.enable    = ctrl_q[CTRL_ENABLE_BIT];
  assign cfg.mode_mask = ctrl_q[CTRL_MODE_MSB:CTRL_MODE_LSB];
  assign cfg.wb_en     = ctrl_q[CTRL_WB_EN_BIT];

  // head window reads as zero while empty
  assign head  = rd.empty ? '0 : rd.head;
  assign count = rd.count;

  always_comb begin
    rd_ok   = 1'b1;
    rd_word = '0;
    case (araddr_i)
      REG_CTRL:      rd_word = 32'(ctrl_q);
      REG_STATUS:    rd_word = {15'b0, rd.empty, 16'(count)};
      REG_DROPS:     rd_word = drops_q;
      REG_HEAD_KIND: rd_word = 32'(head.kind);
      REG_HEAD_LO: begin
        if (head.kind == KIND_WB) begin
          rd_word = head.payload.wb_view.wdata;
        end else begin
          rd_word = head.payload.insn_view.insn;
        end
      end
      REG_HEAD_HI: begin
        if (head.kind == KIND_WB) begin
          rd_word = 32'(head.payload.wb_view.rd_addr);
        end else begin
          rd_word = head.payload.insn_view.pc;
        end
      end
      REG_FLUSH:     rd_word = '0;
      default:       rd_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q   <= '0;
      drops_q  <= '0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_accept && awaddr_i == REG_CTRL) begin
        ctrl_q <= wdata_i[CTRL_W-1:0];
      end

      // any write clears, otherwise count up and stick at max
      if (wr_accept && awaddr_i == REG_DROPS) begin
        drops_q <= '0;
      end else if (cfg.drop_pulse && drops_q != '1) begin
        drops_q <= drops_q + 32'd1;
      end

      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end

      if (rd_accept) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_accept) begin
      rdata_q <= rd_word;
      rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

endmodule

`default_nettype wire

//--- src/trace_top.sv
// ****************************************
// trace tap top, core retirement port as plain ports
// FifoDepth must be a power of two, at most 32768
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module trace_top import trace_pkg::*; #(
  parameter int unsigned FifoDepth = 16
) (
  input  logic        clk_i,
  input  logic        arst_n_i,

  // retirement port of the core
  input  logic        retire_valid_i,
  input  logic [31:0] retire_pc_i,
  input  logic [31:0] retire_insn_i,
  input  logic [4:0]  retire_rd_addr_i,
  input  logic [31:0] retire_rd_wdata_i,
  input  logic        retire_trap_i,
  input  logic [1:0]  retire_mode_i,

  // AXI4-Lite register access
  input  logic [7:0]  awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [7:0]  araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i
);

  retire_t      retire;
  logic         wr_en;
  logic         wr_two;
  trace_entry_t wr_entry0;
  trace_entry_t wr_entry1;
  logic [1:0]   free;

  trace_cfg_if cfg_if ();
  trace_rd_if #(.FifoDepth(FifoDepth)) rd_if ();

  assign retire = '{
    pc:       retire_pc_i,
    insn:     retire_insn_i,
    rd_addr:  retire_rd_addr_i,
    rd_wdata: retire_rd_wdata_i,
    trap:     retire_trap_i,
    mode:     retire_mode_i
  };

  trace_encoder u_trace_encoder (
    .clk_i,
    .arst_n_i,
    .retire_valid_i,
    .retire_i    (retire),
    .cfg         (cfg_if.encoder),
    .free_i      (free),
    .wr_en_o     (wr_en),
    .wr_two_o    (wr_two),
    .wr_entry0_o (wr_entry0),
    .wr_entry1_o (wr_entry1)
  );

  trace_fifo #(
    .FifoDepth (FifoDepth)
  ) u_trace_fifo (
    .clk_i,
    .arst_n_i,
    .wr_en_i     (wr_en),
    .wr_two_i    (wr_two),
    .wr_entry0_i (wr_entry0),
    .wr_entry1_i (wr_entry1),
    .free_o      (free),
    .rd          (rd_if.fifo)
  );

  trace_regs #(
    .FifoDepth (FifoDepth)
  ) u_trace_regs (
    .clk_i,
    .arst_n_i,
    .awaddr_i,
    .awvalid_i,
    .awready_o,
    .wdata_i,
    .wvalid_i,
    .wready_o,
    .bresp_o,
    .bvalid_o,
    .bready_i,
    .araddr_i,
    .arvalid_i,
    .arready_o,
    .rdata_o,
    .rresp_o,
    .rvalid_o,
    .rready_i,
    .cfg (cfg_if.regs),
    .rd  (rd_if.regs)
  );

endmodule

`default_nettype wire

//--- tests/trace_tb.sv
// ****************************************
// testbench for trace_top, run from the project root
// stimulus and expected values come from
// tests/trace_stimulus.txt
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module trace_tb import trace_axil_pkg::*;;

  localparam int max_wait_cycles = 64;

  logic        clk;
  logic        arst_n;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [31:0] retire_insn;
  logic [4:0]  retire_rd_addr;
  logic [31:0] retire_rd_wdata;
  logic        retire_trap;
  logic [1:0]  retire_mode;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_errors = 0;
  bit timed_out = 1'b0;
  int aw_handshakes = 0;
  int w_handshakes = 0;
  int ar_handshakes = 0;

  trace_top #(
    .FifoDepth (16)
  ) trace_top_i (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .retire_valid_i    (retire_valid),
    .retire_pc_i       (retire_pc),
    .retire_insn_i     (retire_insn),
    .retire_rd_addr_i  (retire_rd_addr),
    .retire_rd_wdata_i (retire_rd_wdata),
    .retire_trap_i     (retire_trap),
    .retire_mode_i     (retire_mode),
    .awaddr_i          (awaddr),
    .awvalid_i         (awvalid),
    .awready_o         (awready),
    .wdata_i           (wdata),
    .wvalid_i          (wvalid),
    .wready_o          (wready),
    .bresp_o           (bresp),
    .bvalid_o          (bvalid),
    .bready_i          (bready),
    .araddr_i          (araddr),
    .arvalid_i         (arvalid),
    .arready_o         (arready),
    .rdata_o           (rdata),
    .rresp_o           (rresp),
    .rvalid_o          (rvalid),
    .rready_i          (rready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // accepted requests per channel, inputs settled since the falling edge
  always @(posedge clk) begin
    if (awvalid && awready) begin
      aw_handshakes++;
    end
    if (wvalid && wready) begin
      w_handshakes++;
    end
    if (arvalid && arready) begin
      ar_handshakes++;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, expected);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    test_errors++;
    timed_out = 1'b1;
  endtask

  // one write, address and data offered together
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int cycles;
    int delay;
    int aw_start;
    int w_start;
    cycles = 0;
    resp = 2'b11;
    @(negedge clk);
    aw_start = aw_handshakes;
    w_start  = w_handshakes;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!bvalid && cycles < max_wait_cycles) begin
      @(negedge clk);
      cycles++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!bvalid) begin
      report_timeout("write response");
    end else begin
      check_value("awready pulses", 32'(aw_handshakes - aw_start), 32'd1);
      check_value("wready pulses", 32'(w_handshakes - w_start), 32'd1);
      resp  = bresp;
      delay = $urandom_range(3, 0);
      repeat (delay) @(negedge clk);
      bready = 1'b1;
      cycles = 0;
      while (bvalid && cycles < max_wait_cycles) begin
        @(negedge clk);
        cycles++;
      end
      bready = 1'b0;
      if (bvalid) begin
        report_timeout("write response to clear");
      end
    end
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int cycles;
    int delay;
    int ar_start;
    cycles = 0;
    data = '0;
    resp = 2'b11;
    @(negedge clk);
    ar_start = ar_handshakes;
    araddr  = addr;
    arvalid = 1'b1;
    while (!rvalid && cycles < max_wait_cycles) begin
      @(negedge clk);
      cycles++;
    end
    arvalid = 1'b0;
    if (!rvalid) begin
      report_timeout("read data");
    end else begin
      check_value("arready pulses", 32'(ar_handshakes - ar_start), 32'd1);
      data  = rdata;
      resp  = rresp;
      delay = $urandom_range(3, 0);
      repeat (delay) @(negedge clk);
      rready = 1'b1;
      cycles = 0;
      while (rvalid && cycles < max_wait_cycles) begin
        @(negedge clk);
        cycles++;
      end
      rready = 1'b0;
      if (rvalid) begin
        report_timeout("read data to clear");
      end
    end
  endtask

  // back to back retirements, pc steps by one instruction each time
  task automatic retire_burst(input int num, input logic [31:0] pc, input logic [31:0] insn,
                              input logic [4:0] rd_addr, input logic [31:0] rd_wdata,
                              input logic trap, input logic [1:0] mode);
    int i;
    for (i = 0; i < num; i++) begin
      @(negedge clk);
      retire_valid    = 1'b1;
      retire_pc       = pc + 32'(4 * i);
      retire_insn     = insn;
      retire_rd_addr  = rd_addr;
      retire_rd_wdata = rd_wdata;
      retire_trap     = trap;
      retire_mode     = mode;
    end
    @(negedge clk);
    retire_valid = 1'b0;
    // entries reach the FIFO two edges after the last retirement
    repeat (2) @(negedge clk);
  endtask

  task automatic wait_for_count(input logic [15:0] expected);
    int cycles;
    logic [31:0] status;
    logic [1:0]  resp;
    cycles = 0;
    axi_read(REG_STATUS, status, resp);
    while (status[15:0] != expected && cycles < max_wait_cycles && !timed_out) begin
      axi_read(REG_STATUS, status, resp);
      cycles++;
    end
    if (status[15:0] != expected && !timed_out) begin
      report_timeout($sformatf("FIFO count %0d, last seen %0d", expected, status[15:0]));
    end
  endtask

  initial begin
    string       cmd;
    string       name;
    string       dir;
    string       line;
    int          fd;
    int          n;
    int          num;
    int          expect_count;
    logic [31:0] addr;
    logic [31:0] value;
    logic [31:0] got;
    logic [31:0] pc;
    logic [31:0] insn;
    logic [31:0] rd_addr;
    logic [31:0] rd_wdata;
    logic [31:0] trap;
    logic [31:0] mode;
    logic [1:0]  resp;

    void'($urandom(95611));
    arst_n          = 1'b0;
    retire_valid    = 1'b0;
    retire_pc       = '0;
    retire_insn     = '0;
    retire_rd_addr  = '0;
    retire_rd_wdata = '0;
    retire_trap     = 1'b0;
    retire_mode     = '0;
    awaddr          = '0;
    awvalid         = 1'b0;
    wdata           = '0;
    wvalid          = 1'b0;
    bready          = 1'b0;
    araddr          = '0;
    arvalid         = 1'b0;
    rready          = 1'b0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;

    fd = $fopen("tests/trace_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/trace_stimulus.txt");
      errors++;
    end else begin
      while (!timed_out && $fscanf(fd, "%s", cmd) == 1) begin
        if (cmd == "#") begin
          n = $fgets(line, fd);
        end else if (cmd == "W") begin
          n = $fscanf(fd, "%h %h", addr, value);
          axi_write(addr[7:0], value, resp);
          check_value($sformatf("write %h response", addr[7:0]), 32'(resp), 32'(RESP_OKAY));
        end else if (cmd == "E") begin
          n = $fscanf(fd, "%h %h", addr, value);
          axi_read(addr[7:0], got, resp);
          check_value($sformatf("read %h response", addr[7:0]), 32'(resp), 32'(RESP_OKAY));
          check_value($sformatf("read %h data", addr[7:0]), got, value);
        end else if (cmd == "R") begin
          n = $fscanf(fd, "%d %h %h %h %h %h %h", num, pc, insn, rd_addr, rd_wdata, trap, mode);
          retire_burst(num, pc, insn, rd_addr[4:0], rd_wdata, trap[0], mode[1:0]);
        end else if (cmd == "S") begin
          n = $fscanf(fd, "%d", expect_count);
          wait_for_count(expect_count[15:0]);
        end else if (cmd == "X") begin
          n = $fscanf(fd, "%s %h", dir, addr);
          if (dir == "w") begin
            axi_write(addr[7:0], 32'hffff_ffff, resp);
          end else begin
            axi_read(addr[7:0], got, resp);
          end
          check_value($sformatf("%s %h error response", dir, addr[7:0]), 32'(resp),
                      32'(RESP_SLVERR));
        end else if (cmd == "T") begin
          n = $fscanf(fd, "%s", name);
          tests++;
          $display("test %s %s, %0d errors", name, (test_errors == 0) ? "passed" : "FAILED",
                   test_errors);
          test_errors = 0;
        end else begin
          $display("unknown stimulus command %s", cmd);
          errors++;
        end
      end
      $fclose(fd);
    end

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/trace_stimulus.txt
# W addr data | E addr expected | X r/w addr | S fifo_count | T test_name
# R count pc insn rd_addr rd_wdata trap mode, pc steps by 4 per repeat
E 00 00000000
E 04 00010000
E 08 00000000
T reset
R 1 00001000 00000013 01 00000011 0 0
W 00 00000003
R 1 00001004 00000013 01 00000011 0 3
E 04 00010000
E 08 00000000
T filter
R 1 00002000 00200113 02 00000055 0 0
W 00 00000023
R 1 00002004 00a00093 01 0000abcd 0 0
R 1 00002008 00000013 00 00000000 0 0
S 4
E 0c 00000000
E 14 00002000
E 0c 00000000
E 10 00a00093
E 14 00002004
E 0c 00000002
E 10 0000abcd
E 14 00000001
E 0c 00000000
E 14 00002008
E 04 00010000
T writeback
R 1 00003000 00000073 05 12345678 1 0
S 1
E 0c 00000001
E 10 00000073
E 14 00003000
E 04 00010000
T trap
R 10 00004000 00000093 01 00000001 0 0
S 16
E 04 00000010
E 08 00000002
W 08 00000000
E 08 00000000
W 18 00000001
E 04 00010000
T overflow
X r 1c
X w 04
E 00 00000023
T slverr

//--- filelist.f
src/trace_pkg.sv
src/trace_axil_pkg.sv
src/trace_ifs.sv
src/trace_encoder.sv
src/trace_fifo.sv
src/trace_regs.sv
src/trace_top.sv
tests/trace_tb.sv

//--- run_sim.sh
#!/bin/sh
# compiles trace_tb with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f filelist.f --top-module trace_tb -o trace_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/trace_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
